// File: filelist.f
common/flt_cfg_pkg.sv
common/flt_fixp_pkg.sv
biquad/flt_tap_delay.sv
biquad/flt_biquad.sv
logic/flt_param_regs.sv
logic/flt_top.sv
verif/flt_assertions.sv
verif/flt_tb.sv

// File: verif/flt_tb.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// testbench of the filter block
// drives register writes and sample sequences on the falling edge,
// the bound checker compares every output against its model
// ----------------------------------------------------------------------
module flt_tb
  import flt_cfg_pkg::*, flt_fixp_pkg::*;
();

  localparam word_t C_ZERO        = 32'h0000_0000;
  localparam word_t C_QUARTER     = 32'h1000_0000;   // 0.25 in Q2.30
  localparam word_t C_HALF        = 32'h2000_0000;
  localparam word_t C_ONE         = 32'h4000_0000;
  localparam word_t C_ONE_HALF    = 32'h6000_0000;   // gain above one
  localparam word_t C_NEG_HALF    = 32'hE000_0000;   // -0.5
  localparam int    QUIET_TIMEOUT = 200;             // cycles

  logic    Clk_CI;
  logic    Rst_RBI;
  logic    wr_en;
  addr_t   addr;
  word_t   wr_data;
  sample_t sample_in;
  sample_t sample_out;
  integer  seed;

  flt_top u_flt_top (
    .Clk_CI     ( Clk_CI     ),
    .Rst_RBI    ( Rst_RBI    ),
    .wr_en      ( wr_en      ),
    .addr       ( addr       ),
    .wr_data    ( wr_data    ),
    .sample_in  ( sample_in  ),
    .sample_out ( sample_out )
  );

  initial begin
    Clk_CI = 1'b0;
    forever #2 Clk_CI = ~Clk_CI;                     // 4 ns period
  end

  task automatic fail_and_stop(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // first checker error ends the run
  always @(negedge Clk_CI) begin
    if (u_flt_top.u_chk.fail_cnt != 0) begin
      fail_and_stop($sformatf("[FAIL] t=%0t: output or coefficients off the reference", $time));
    end
  end

  // ----------------------------------------------------------------------
  // drivers, all start and end on a falling edge
  // ----------------------------------------------------------------------
  task automatic write_reg(input addr_t a, input word_t d);
    addr    = a;
    wr_data = d;
    wr_en   = 1'b1;                                  // taken at next rising edge
    @(negedge Clk_CI);
    wr_en   = 1'b0;
  endtask

  task automatic load_coefs(input word_t s, input word_t c_b0, input word_t c_b1,
                            input word_t c_a1, input word_t c_a2);
    write_reg(ADDR_SD, s);
    write_reg(ADDR_B0, c_b0);
    write_reg(ADDR_B1, c_b1);
    write_reg(ADDR_A1, c_a1);
    write_reg(ADDR_A2, c_a2);
    write_reg(ADDR_COMMIT, C_ZERO);                  // whole set at once
  endtask

  task automatic drive_random(input int n);
    for (int i = 0; i < n; i++) begin
      sample_in = sample_t'($random(seed));          // full-scale noise
      @(negedge Clk_CI);
    end
  endtask

  task automatic drive_level(input sample_t v, input int n);
    sample_in = v;
    repeat (n) @(negedge Clk_CI);
    sample_in = '0;
  endtask

  // zero input until the output stays at zero
  task automatic wait_quiet(input int quiet_len);
    int cnt;
    int zeros;
    cnt   = 0;
    zeros = 0;
    sample_in = '0;
    while (zeros < quiet_len && cnt < QUIET_TIMEOUT) begin
      @(negedge Clk_CI);
      zeros = (sample_out == '0) ? zeros + 1 : 0;
      cnt++;
    end
    if (zeros < quiet_len) begin
      fail_and_stop("timeout: sample_out did not settle to zero");
    end
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial begin
    seed      = 32'hd6f2eb83;
    Rst_RBI   = 1'b0;
    wr_en     = 1'b0;
    addr      = '0;
    wr_data   = '0;
    sample_in = '0;
    repeat (16) @(negedge Clk_CI);
    Rst_RBI = 1'b1;

    repeat (4) @(negedge Clk_CI);                    // zero in, zero out
    drive_random(40);                                // reset-default low-pass
    drive_level('0, 8);

    load_coefs(C_ONE, C_ONE, C_ZERO, C_ZERO, C_ZERO); // b2 follows b0
    drive_random(32);
    wait_quiet(4);

    load_coefs(C_ONE, C_HALF, C_QUARTER, C_ZERO, C_ZERO);
    drive_level(24'sh40_0000, 1);                    // impulse of 0.5
    wait_quiet(4);

    load_coefs(C_ONE, C_HALF, C_ZERO, C_NEG_HALF, C_ZERO);
    drive_level(24'sh40_0000, 1);                    // decays through y[n-1]
    wait_quiet(4);

    write_reg(ADDR_B0, C_QUARTER);                   // staged only
    write_reg(ADDR_B1, C_HALF);
    write_reg(ADDR_A1, C_ZERO);
    drive_random(16);
    write_reg(3'd6, C_ONE);                          // unmapped
    write_reg(3'd7, C_ONE);
    drive_random(8);
    write_reg(ADDR_COMMIT, C_ZERO);
    drive_random(16);
    wait_quiet(4);

    load_coefs(C_ONE, C_ONE_HALF, C_ONE_HALF, C_ZERO, C_ZERO);
    drive_level(24'sh7F_FFFF, 8);                    // clamp high
    drive_level(24'sh80_0000, 8);                    // clamp low
    wait_quiet(4);

    repeat (4) @(negedge Clk_CI);
    if (u_flt_top.u_chk.fail_cnt != 0) begin
      fail_and_stop($sformatf("[FAIL] t=%0t: checker reported errors", $time));
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: verif/flt_assertions.sv
`timescale 1ns/1ps
// ----------------------------------------------------------------------
// bound checker of the filter block
// holds its own model of the parameter banks and the biquad rule,
// fed only from top-level ports, and checks sample_out every clock
// ----------------------------------------------------------------------
module flt_assertions
  import flt_cfg_pkg::*, flt_fixp_pkg::*;
(
  input logic    Clk_CI,
  input logic    Rst_RBI,
  input logic    wr_en,
  input addr_t   addr,
  input word_t   wr_data,
  input sample_t sample_in,
  input sample_t sample_out,
  input coef_t   sd,                               // active set inside the top
  input coef_t   b0,
  input coef_t   b1,
  input coef_t   a1,
  input coef_t   a2
);

  typedef logic signed [95:0] wide_t;              // no wrap in the model

  int      fail_cnt = 0;                           // watched by the testbench
  word_t   stg_m [NUM_REGS];                       // model staging bank
  word_t   act_m [NUM_REGS];                       // model active bank
  sample_t in_m;
  state_t  x_m;
  state_t  x1_m;
  state_t  x2_m;
  state_t  y_m;
  state_t  y1_m;
  state_t  y2_m;
  wide_t   acc_w;
  wide_t   y_w;
  wide_t   o_w;
  sample_t exp_out;
  logic    clip_hi;
  logic    clip_lo;

  // ----------------------------------------------------------------------
  // register map and history model
  // ----------------------------------------------------------------------
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      stg_m <= '{RST_SD, RST_B0, RST_B1, RST_A1, RST_A2};
      act_m <= '{RST_SD, RST_B0, RST_B1, RST_A1, RST_A2};
      in_m  <= '0;
      x1_m  <= '0;
      x2_m  <= '0;
      y1_m  <= '0;
      y2_m  <= '0;
    end else begin
      if (wr_en) begin
        case (addr)
          ADDR_SD, ADDR_B0, ADDR_B1, ADDR_A1, ADDR_A2: stg_m[addr] <= wr_data;
          ADDR_COMMIT: act_m <= stg_m;             // data word ignored
          default: ;                               // 6 and 7 do nothing
        endcase
      end
      in_m <= sample_in;
      x1_m <= x_m;
      x2_m <= x1_m;
      y1_m <= y_m;
      y2_m <= y1_m;
    end
  end

  // filter rule on wide integers
  always_comb begin
    x_m   = state_t'((wide_t'(in_m) * wide_t'(coef_t'(act_m[ADDR_SD]))) >>> SAMPLE_FRAC);
    acc_w = wide_t'(coef_t'(act_m[ADDR_B0])) * wide_t'(x_m)
          + wide_t'(coef_t'(act_m[ADDR_B1])) * wide_t'(x1_m)
          + wide_t'(coef_t'(act_m[ADDR_B0])) * wide_t'(x2_m)
          - wide_t'(coef_t'(act_m[ADDR_A1])) * wide_t'(y1_m)
          - wide_t'(coef_t'(act_m[ADDR_A2])) * wide_t'(y2_m);
    y_w   = acc_w >>> COEF_FRAC;
    if (y_w > wide_t'(STATE_MAX)) begin
      y_m = STATE_MAX;
    end else if (y_w < wide_t'(STATE_MIN)) begin
      y_m = STATE_MIN;
    end else begin
      y_m = state_t'(y_w);
    end
    o_w   = wide_t'(y_m) >>> (COEF_FRAC - SAMPLE_FRAC);
    if (o_w > wide_t'(SAMPLE_MAX)) begin
      exp_out = SAMPLE_MAX;
    end else if (o_w < wide_t'(SAMPLE_MIN)) begin
      exp_out = SAMPLE_MIN;
    end else begin
      exp_out = sample_t'(o_w);
    end
    clip_hi = (acc_w >>> (2 * COEF_FRAC - SAMPLE_FRAC)) > wide_t'(SAMPLE_MAX);
    clip_lo = (acc_w >>> (2 * COEF_FRAC - SAMPLE_FRAC)) < wide_t'(SAMPLE_MIN);
  end

  // ----------------------------------------------------------------------
  // checks
  // ----------------------------------------------------------------------
  a_out_match: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    sample_out == exp_out)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("sample_out %0d, reference %0d", sample_out, exp_out);
    end

  a_coef_match: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    {sd, b0, b1, a1, a2} == {act_m[ADDR_SD], act_m[ADDR_B0], act_m[ADDR_B1],
                             act_m[ADDR_A1], act_m[ADDR_A2]})
    else begin
      fail_cnt = fail_cnt + 1;
      $error("active coefficient set differs from the committed set");
    end

  a_reset_zero: assert property (@(posedge Clk_CI) $rose(Rst_RBI) |-> sample_out == '0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("sample_out not zero after reset");
    end

  a_clip_hi: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    clip_hi |-> sample_out == SAMPLE_MAX)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("positive overflow not clamped, got %0d", sample_out);
    end

  a_clip_lo: assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    clip_lo |-> sample_out == SAMPLE_MIN)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("negative overflow not clamped, got %0d", sample_out);
    end

endmodule

bind flt_top flt_assertions u_chk (
  .Clk_CI     ( Clk_CI     ),
  .Rst_RBI    ( Rst_RBI    ),
  .wr_en      ( wr_en      ),
  .addr       ( addr       ),
  .wr_data    ( wr_data    ),
  .sample_in  ( sample_in  ),
  .sample_out ( sample_out ),
  .sd         ( sd         ),
  .b0         ( b0         ),
  .b1         ( b1         ),
  .a1         ( a1         ),
  .a2         ( a2         )
);

// File: logic/flt_top.sv
`timescale 1ns/1ps
// ------------------------------------------------------------------
// filter block top level
// parameter write port on one side, sample stream on the other,
// one cycle from sample_in to sample_out
// ------------------------------------------------------------------
module flt_top
  import flt_cfg_pkg::*, flt_fixp_pkg::*;
(
  input  logic    Clk_CI,
  input  logic    Rst_RBI,
  input  logic    wr_en,                           // parameter write strobe
  input  addr_t   addr,
  input  word_t   wr_data,
  input  sample_t sample_in,
  output sample_t sample_out
);

  // active coefficient set
  coef_t sd;
  coef_t b0;
  coef_t b1;
  coef_t a1;
  coef_t a2;

  flt_param_regs u_param_regs (
    .Clk_CI  ( Clk_CI  ),
    .Rst_RBI ( Rst_RBI ),
    .wr_en   ( wr_en   ),
    .addr    ( addr    ),
    .wr_data ( wr_data ),
    .sd      ( sd      ),
    .b0      ( b0      ),
    .b1      ( b1      ),
    .a1      ( a1      ),
    .a2      ( a2      )
  );

  flt_biquad u_biquad (
    .Clk_CI     ( Clk_CI     ),
    .Rst_RBI    ( Rst_RBI    ),
    .sample_in  ( sample_in  ),
    .sd         ( sd         ),
    .b0         ( b0         ),
    .b1         ( b1         ),
    .a1         ( a1         ),
    .a2         ( a2         ),
    .sample_out ( sample_out )
  );

endmodule

// File: logic/flt_param_regs.sv
`timescale 1ns/1ps
// ------------------------------------------------------------------
// parameter memory of the filter with a staging and an active bank
// writes land in staging, a write to the commit address moves the
// whole set to the active bank that feeds the biquad
// ------------------------------------------------------------------
module flt_param_regs
  import flt_cfg_pkg::*, flt_fixp_pkg::*;
(
  input  logic  Clk_CI,
  input  logic  Rst_RBI,
  input  logic  wr_en,                             // single-cycle write strobe
  input  addr_t addr,
  input  word_t wr_data,
  output coef_t sd,
  output coef_t b0,
  output coef_t b1,
  output coef_t a1,
  output coef_t a2
);

  word_t stage_q  [NUM_REGS];                      // software-visible set
  word_t active_q [NUM_REGS];                      // set in use by datapath
  logic  stage_we;
  logic  commit;

  // address decode, 6 and 7 fall through
  assign stage_we = wr_en && (addr < addr_t'(NUM_REGS));
  assign commit   = wr_en && (addr == ADDR_COMMIT);

  // ------------------------------------------------------------------
  // staging and active banks
  // ------------------------------------------------------------------
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      stage_q  <= RST_BANK;                        // both banks start from defaults
      active_q <= RST_BANK;
    end else begin
      if (stage_we) begin
        stage_q[addr] <= wr_data;                  // one word at a time
      end
      if (commit) begin
        active_q <= stage_q;                       // whole set in one edge
      end
    end
  end

  // active coefficients to the biquad
  assign sd = coef_t'(active_q[ADDR_SD]);
  assign b0 = coef_t'(active_q[ADDR_B0]);
  assign b1 = coef_t'(active_q[ADDR_B1]);
  assign a1 = coef_t'(active_q[ADDR_A1]);
  assign a2 = coef_t'(active_q[ADDR_A2]);

endmodule

// File: biquad/flt_biquad.sv
`timescale 1ns/1ps
// ------------------------------------------------------------------
// direct-form-I biquad, one sample in and one sample out per clock
// input is registered and scaled by sd, output follows combinationally
// from the input register and the x/y histories, b2 reuses b0
// ------------------------------------------------------------------
module flt_biquad
  import flt_fixp_pkg::*;
(
  input  logic    Clk_CI,
  input  logic    Rst_RBI,
  input  sample_t sample_in,                       // Q1.23
  input  coef_t   sd,                              // scale-down, Q2.30
  input  coef_t   b0,
  input  coef_t   b1,
  input  coef_t   a1,
  input  coef_t   a2,
  output sample_t sample_out                       // Q1.23, saturated
);

  sample_t in_q;                                   // registered input
  acc_t    scale_full;                             // Q3.53 scaled product
  state_t  x_n;                                    // scaled input, Q2.30
  state_t  x1;
  state_t  x2;
  state_t  y_n;                                    // saturated y[n]
  state_t  y1;
  state_t  y2;
  acc_t    acc_sum;                                // Q4.60 tap sum
  acc_t    y_full;                                 // sum back at 30 frac bits
  state_t  y_out;                                  // y[n] at 23 frac bits

  // sign-extended coefficient times state, Q4.60
  function automatic acc_t mac_term(input coef_t c, input state_t s);
    return acc_t'(c) * acc_t'(s);
  endfunction

  // ------------------------------------------------------------------
  // input register and scale-down
  // ------------------------------------------------------------------
  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      in_q <= '0;
    end else begin
      in_q <= sample_in;                           // no back-pressure
    end
  end

  assign scale_full = acc_t'(in_q) * acc_t'(sd);
  assign x_n        = state_t'(scale_full >>> SAMPLE_FRAC); // truncate to Q2.30

  // ------------------------------------------------------------------
  // sample histories
  // ------------------------------------------------------------------
  flt_tap_delay #(
    .T       ( state_t )
  ) u_x_hist (
    .Clk_CI  ( Clk_CI  ),
    .Rst_RBI ( Rst_RBI ),
    .d       ( x_n     ),
    .q1      ( x1      ),
    .q2      ( x2      )
  );

  flt_tap_delay #(
    .T       ( state_t )
  ) u_y_hist (
    .Clk_CI  ( Clk_CI  ),
    .Rst_RBI ( Rst_RBI ),
    .d       ( y_n     ),
    .q1      ( y1      ),
    .q2      ( y2      )
  );

  // ------------------------------------------------------------------
  // feed-forward and feedback sum
  // ------------------------------------------------------------------
  assign acc_sum = mac_term(b0, x_n)               // b0 x[n]
                 + mac_term(b1, x1)                // b1 x[n-1]
                 + mac_term(b0, x2)                // b2 = b0
                 - mac_term(a1, y1)
                 - mac_term(a2, y2);

  assign y_full = acc_sum >>> COEF_FRAC;           // floor to Q2.30

  // clamp y[n] before it enters the feedback path
  always_comb begin
    if (y_full > acc_t'(STATE_MAX)) begin
      y_n = STATE_MAX;
    end else if (y_full < acc_t'(STATE_MIN)) begin
      y_n = STATE_MIN;
    end else begin
      y_n = state_t'(y_full);
    end
  end

  // ------------------------------------------------------------------
  // output reduction to Q1.23
  // ------------------------------------------------------------------
  assign y_out = y_n >>> OUT_SHIFT;                // rounds toward -inf

  always_comb begin
    if (y_out > state_t'(SAMPLE_MAX)) begin
      sample_out = SAMPLE_MAX;                     // clip high
    end else if (y_out < state_t'(SAMPLE_MIN)) begin
      sample_out = SAMPLE_MIN;                     // clip low
    end else begin
      sample_out = sample_t'(y_out);
    end
  end

endmodule

// File: biquad/flt_tap_delay.sv
`timescale 1ns/1ps
// ------------------------------------------------------------------
// two-deep sample history for the biquad
// shifts every clock, q1 is one sample old and q2 two samples old
// ------------------------------------------------------------------
module flt_tap_delay
  import flt_fixp_pkg::*;
#(
  parameter type T = state_t                       // payload of one tap
)
(
  input  logic Clk_CI,
  input  logic Rst_RBI,
  input  T     d,                                  // current sample
  output T     q1,                                 // d delayed by one
  output T     q2                                  // d delayed by two
);

  always_ff @(posedge Clk_CI or negedge Rst_RBI) begin
    if (!Rst_RBI) begin
      q1 <= '0;                                    // empty history
      q2 <= '0;
    end else begin
      q1 <= d;
      q2 <= q1;                                    // shift down
    end
  end

endmodule

// File: common/flt_fixp_pkg.sv
// ------------------------------------------------------------------
// fixed-point formats of the biquad datapath
// samples are Q1.23, coefficients and internal state Q2.30,
// products summed in a 64-bit Q4.60 accumulator
// ------------------------------------------------------------------
package flt_fixp_pkg;

  // ------------------------------------------------------------------
  // widths and fraction bits
  // ------------------------------------------------------------------
  localparam int SAMPLE_WIDTH = 24;                // external sample, Q1.23
  localparam int SAMPLE_FRAC  = 23;
  localparam int COEF_WIDTH   = 32;                // coefficient, Q2.30
  localparam int COEF_FRAC    = 30;
  localparam int STATE_WIDTH  = 32;                // internal sample, Q2.30
  localparam int ACC_WIDTH    = 64;                // product sum, Q4.60

  // state to sample alignment
  localparam int OUT_SHIFT = COEF_FRAC - SAMPLE_FRAC;

  // ------------------------------------------------------------------
  // types
  // ------------------------------------------------------------------
  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic signed [COEF_WIDTH-1:0]   coef_t;
  typedef logic signed [STATE_WIDTH-1:0]  state_t;
  typedef logic signed [ACC_WIDTH-1:0]    acc_t;

  // ------------------------------------------------------------------
  // saturation bounds
  // ------------------------------------------------------------------
  localparam state_t STATE_MAX =
    state_t'({1'b0, {(STATE_WIDTH-1){1'b1}}});     // just below 2.0
  localparam state_t STATE_MIN =
    state_t'({1'b1, {(STATE_WIDTH-1){1'b0}}});     // -2.0
  localparam sample_t SAMPLE_MAX =
    sample_t'({1'b0, {(SAMPLE_WIDTH-1){1'b1}}});   // just below 1.0
  localparam sample_t SAMPLE_MIN =
    sample_t'({1'b1, {(SAMPLE_WIDTH-1){1'b0}}});   // -1.0

endpackage

// File: common/flt_cfg_pkg.sv
// ------------------------------------------------------------------
// register map of the filter parameter memory
// addresses, word types and reset defaults seen by the write port
// reset set is a mild low-pass, all coefficients in Q2.30
// ------------------------------------------------------------------
package flt_cfg_pkg;

  // ------------------------------------------------------------------
  // widths and types
  // ------------------------------------------------------------------
  localparam int ADDR_WIDTH = 3;                   // 8 slots, 6 used
  localparam int WORD_WIDTH = 32;                  // one parameter word

  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [WORD_WIDTH-1:0] word_t;

  // ------------------------------------------------------------------
  // register addresses
  // ------------------------------------------------------------------
  localparam addr_t ADDR_SD     = 3'd0;            // input scale-down
  localparam addr_t ADDR_B0     = 3'd1;            // b0, also used as b2
  localparam addr_t ADDR_B1     = 3'd2;            // b1
  localparam addr_t ADDR_A1     = 3'd3;            // feedback a1
  localparam addr_t ADDR_A2     = 3'd4;            // feedback a2
  localparam addr_t ADDR_COMMIT = 3'd5;            // staging -> active, data ignored

  localparam int NUM_REGS = 5;                     // staged words, 6 and 7 unused

  // ------------------------------------------------------------------
  // reset defaults, Q2.30
  // ------------------------------------------------------------------
  localparam word_t RST_SD = 32'h2000_0000;        // 0.5
  localparam word_t RST_B0 = 32'h0400_0000;        // 0.0625
  localparam word_t RST_B1 = 32'h0800_0000;        // 0.125
  localparam word_t RST_A1 = 32'hC000_0000;        // -1.0
  localparam word_t RST_A2 = 32'h1000_0000;        // 0.25, double pole at 0.5

  // bank image in address order
  localparam word_t RST_BANK [NUM_REGS] = '{RST_SD, RST_B0, RST_B1, RST_A1, RST_A2};

endpackage
